/* routerArbiter.f */
+incdir+source
source/nocFlitPkg.sv
source/arbPkg.sv
source/headDecoder.sv
source/portTimer.sv
source/switchArbiter.sv
source/routerArbiter.sv
tb/tb_routerArbiter.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f routerArbiter.f --top-module tb_routerArbiter \
  -Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_routerArbiter > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

/* source/arbPkg.sv */
`include "routerArb_consts.svh"

package arbPkg;

  // one bit per state, IDLE sits in bit 0 so the grant is the upper slice
  typedef enum logic [`NUM_PORTS:0]
  {
    IDLE  = 6'b000001,
    GNT_L = 6'b000010,
    GNT_N = 6'b000100,
    GNT_E = 6'b001000,
    GNT_W = 6'b010000,
    GNT_S = 6'b100000
  } arbState_t;

  // one-hot grant to the output port, same bit order as the requests
  typedef logic [`NUM_PORTS-1:0] grant_t;

endpackage

/* source/headDecoder.sv */
`include "routerArb_consts.svh"

module headDecoder
(
  input  logic                                     clk,
  input  logic                                     rst,
  input  nocFlitPkg::flitId_t [`NUM_PORTS-1:0]     flitId,
  input  nocFlitPkg::pktLen_t [`NUM_PORTS-1:0]     pktLen,
  output nocFlitPkg::pktLen_t [`NUM_PORTS-1:0]     budget
);

  import nocFlitPkg::*;

  portVec_t isHead;

  // a head flit is recognised by its id alone, in the cycle it appears
  always_comb
  begin
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      isHead[p] = (flitId[p] == flitId_t'(`HEAD_ID));
    end
  end

  // budget follows the length of the latest head flit on that port
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
    end
    else
    begin
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        if (isHead[p])
        begin
          budget[p] <= pktLen[p]; // body and tail flits keep the old budget
        end
      end
    end
  end

endmodule

/* source/nocFlitPkg.sv */
`include "routerArb_consts.svh"

package nocFlitPkg;

  // position of a flit inside its packet
  typedef logic [`FLIT_ID_W-1:0] flitId_t;

  // packet length in flits, reused as time budget and tenure count
  typedef logic [`PKT_LEN_W-1:0] pktLen_t;

  // one bit per port, L N E W S from bit 0
  typedef logic [`NUM_PORTS-1:0] portVec_t;

  // index of a single port, 0 is Local
  typedef logic [2:0] portIdx_t;

endpackage

/* source/portTimer.sv */
`include "routerArb_consts.svh"

module portTimer
(
  input  logic                clk,
  input  logic                rst,
  input  nocFlitPkg::pktLen_t budget,
  input  logic                run,
  output logic                timesUp
);

  import nocFlitPkg::*;

  pktLen_t count;

  // counts the cycles of a continuing tenure
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (run)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0; // tenure over or never started
    end
  end

  // with run held this rises on the budget-th cycle of the tenure,
  // so the holder keeps the port for budget+1 cycles
  assign timesUp = (count == budget);

  // while the budget holds still, a running count stops at the budget
  // and never steps past it
  countBoundA: assert property (
    @(posedge clk) disable iff (rst)
    (run && count <= budget) ##1 $stable(budget) |-> count <= budget
  );

endmodule

/* source/routerArb_consts.svh */
`ifndef ROUTERARB_CONSTS_SVH
`define ROUTERARB_CONSTS_SVH

// router geometry, fixed for this mesh node
`define NUM_PORTS 5

// flit header fields
`define FLIT_ID_W 3
`define PKT_LEN_W 12

// flit id carried by the first flit of a packet
`define HEAD_ID 1

`endif

/* source/routerArbiter.sv */
`include "routerArb_consts.svh"

module routerArbiter
(
  input  logic                                 clk,
  input  logic                                 rst,
  input  nocFlitPkg::flitId_t [`NUM_PORTS-1:0] flitId,
  input  nocFlitPkg::pktLen_t [`NUM_PORTS-1:0] pktLen,
  input  nocFlitPkg::portVec_t                 req,
  output arbPkg::grant_t                       grant
);

  import nocFlitPkg::*;

  pktLen_t [`NUM_PORTS-1:0] budget;
  portVec_t                 runTimer;
  portVec_t                 timesUp;

  headDecoder uHeadDecoder
  (
    .clk    (clk),
    .rst    (rst),
    .flitId (flitId),
    .pktLen (pktLen),
    .budget (budget)
  );

  // one tenure timer per input port
  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : gTimer
    portTimer uPortTimer
    (
      .clk     (clk),
      .rst     (rst),
      .budget  (budget[p]),
      .run     (runTimer[p]),
      .timesUp (timesUp[p])
    );
  end

  switchArbiter uSwitchArbiter
  (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .timesUp  (timesUp),
    .runTimer (runTimer),
    .grant    (grant)
  );

endmodule

/* source/switchArbiter.sv */
`include "routerArb_consts.svh"

module switchArbiter
(
  input  logic                 clk,
  input  logic                 rst,
  input  nocFlitPkg::portVec_t req,
  input  nocFlitPkg::portVec_t timesUp,
  output nocFlitPkg::portVec_t runTimer,
  output arbPkg::grant_t       grant
);

  import nocFlitPkg::*;
  import arbPkg::*;

  arbState_t state;
  arbState_t nextState;
  portIdx_t  holder;

  // grant state for a given port index
  function automatic arbState_t stateOf(portIdx_t idx);
    arbState_t s;
    case (idx)
      3'd0:    s = GNT_L;
      3'd1:    s = GNT_N;
      3'd2:    s = GNT_E;
      3'd3:    s = GNT_W;
      3'd4:    s = GNT_S;
      default: s = IDLE;
    endcase
    return s;
  endfunction

  // first requesting port among span ports, starting at start and wrapping
  function automatic arbState_t pickFrom(portVec_t reqs, int start, int span);
    arbState_t pick;
    int idx;
    pick = IDLE;
    for (int k = span - 1; k >= 0; k--)
    begin
      idx = (start + k) % `NUM_PORTS; // walk backwards so the nearest port wins
      if (reqs[idx])
      begin
        pick = stateOf(portIdx_t'(idx));
      end
    end
    return pick;
  endfunction

  always_comb
  begin
    case (state)
      GNT_N:   holder = 3'd1;
      GNT_E:   holder = 3'd2;
      GNT_W:   holder = 3'd3;
      GNT_S:   holder = 3'd4;
      default: holder = 3'd0; // also covers IDLE, which never reads it
    endcase
  end

  always_comb
  begin
    nextState = IDLE;
    runTimer  = '0;
    case (state)
      IDLE:
      begin
        nextState = pickFrom(req, 0, `NUM_PORTS); // fixed order L N E W S
      end
      GNT_L, GNT_N, GNT_E, GNT_W, GNT_S:
      begin
        if (req[holder] && !timesUp[holder])
        begin
          runTimer[holder] = 1'b1;
          nextState        = state;
        end
        else
        begin
          // rotate past the holder, which is left out of this round
          nextState = pickFrom(req, int'(holder) + 1, `NUM_PORTS - 1);
        end
      end
      default:
      begin
        nextState = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

  assign grant = state[`NUM_PORTS:1]; // straight from the state register

  stateOneHotA: assert property (
    @(posedge clk) disable iff (rst)
    $onehot(state)
  );

  runMatchesGrantA: assert property (
    @(posedge clk) disable iff (rst)
    runTimer == '0 || runTimer == grant
  );

  // the grant register is loaded from the requests of the cycle before
  grantWasRequestedA: assert property (
    @(posedge clk) disable iff (rst)
    (grant & ~$past(req)) == '0
  );

endmodule

/* tb/tb_routerArbiter.sv */
`include "routerArb_consts.svh"

module tb_routerArbiter;

  timeunit 1ns;
  timeprecision 1ps;

  import nocFlitPkg::*;
  import arbPkg::*;

  localparam int RANDOM_CYCLES   = 2000;
  localparam int DIRECTED_CYCLES = 400; // generous bound for reset and the directed part
  localparam int MAX_CYCLES      = RANDOM_CYCLES + DIRECTED_CYCLES + 600;

  logic                     clk;
  logic                     rst;
  flitId_t [`NUM_PORTS-1:0] flitId;
  pktLen_t [`NUM_PORTS-1:0] pktLen;
  portVec_t                 req;
  grant_t                   grant;

  integer seed;
  int     cycleCount;
  int     tenure;

  // reference model state, advanced once per rising edge
  pktLen_t  modelBudget [`NUM_PORTS];
  pktLen_t  modelCount  [`NUM_PORTS];
  logic     modelIdle;
  portIdx_t modelHolder;
  grant_t   expGrant;

  routerArbiter dut0
  (
    .clk    (clk),
    .rst    (rst),
    .flitId (flitId),
    .pktLen (pktLen),
    .req    (req),
    .grant  (grant)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #5 clk = ~clk;
    end
  end

  // advances the model by one clock edge and returns the grant after it
  function automatic grant_t refNext(portVec_t reqNow, flitId_t [`NUM_PORTS-1:0] idNow,
                                     pktLen_t [`NUM_PORTS-1:0] lenNow);
    portVec_t run;
    logic     nextIdle;
    portIdx_t nextHolder;
    portIdx_t cand;
    grant_t   result;
    run        = '0;
    nextIdle   = 1'b1;
    nextHolder = '0;
    if (modelIdle)
    begin
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        if (reqNow[p] && nextIdle)
        begin
          nextIdle   = 1'b0;
          nextHolder = portIdx_t'(p);
        end
      end
    end
    else if (reqNow[modelHolder] && modelCount[modelHolder] != modelBudget[modelHolder])
    begin
      run[modelHolder] = 1'b1; // tenure continues
      nextIdle         = 1'b0;
      nextHolder       = modelHolder;
    end
    else
    begin
      for (int k = 1; k < `NUM_PORTS; k++)
      begin
        cand = portIdx_t'((int'(modelHolder) + k) % `NUM_PORTS); // holder itself is skipped
        if (reqNow[cand] && nextIdle)
        begin
          nextIdle   = 1'b0;
          nextHolder = cand;
        end
      end
    end
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      modelCount[p] = run[p] ? modelCount[p] + 1'b1 : '0;
      if (idNow[p] == flitId_t'(`HEAD_ID))
      begin
        modelBudget[p] = lenNow[p];
      end
    end
    modelIdle   = nextIdle;
    modelHolder = nextHolder;
    result      = modelIdle ? '0 : grant_t'(1) << modelHolder;
    return result;
  endfunction

  task automatic checkVal(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("ERR %s expected %h got %h", name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic waitCycles(int n);
    repeat (n) @(negedge clk);
  endtask

  // a single head flit on one port, back to a body id after one cycle
  task automatic loadBudget(portIdx_t port, int len);
    flitId[port] = flitId_t'(`HEAD_ID);
    pktLen[port] = pktLen_t'(len);
    @(negedge clk);
    flitId[port] = '0;
  endtask

  task automatic waitGrant(grant_t target);
    while (grant != target)
    begin
      @(negedge clk);
    end
  endtask

  // returns at the first falling edge where the port no longer holds the grant
  task automatic measureTenure(grant_t target, output int len);
    len = 0;
    waitGrant(target);
    while (grant == target)
    begin
      len++;
      @(negedge clk);
    end
  endtask

  task automatic randomPhase(int cycles);
    for (int c = 0; c < cycles; c++)
    begin
      @(negedge clk);
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        if (($random(seed) & 3) == 0)
        begin
          req[p] = ~req[p]; // requests toggle now and then so tenures vary in length
        end
        flitId[p] = flitId_t'($random(seed));
        pktLen[p] = pktLen_t'($random(seed) & 15);
      end
    end
  endtask

  // compares the DUT grant with the model on every cycle
  initial
  begin
    forever
    begin
      @(posedge clk);
      if (rst)
      begin
        modelIdle   = 1'b1;
        modelHolder = '0;
        expGrant    = '0;
        for (int p = 0; p < `NUM_PORTS; p++)
        begin
          modelBudget[p] = '0;
          modelCount[p]  = '0;
        end
      end
      else
      begin
        expGrant = refNext(req, flitId, pktLen);
      end
      @(negedge clk);
      checkVal("grant", 32'(expGrant), 32'(grant));
    end
  end

  initial
  begin
    cycleCount = 0;
    while (cycleCount < MAX_CYCLES)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("the tests did not finish within %0d cycles", MAX_CYCLES);
    $display("=== FAIL ===");
    $fatal(1, "timeout");
  end

  initial
  begin
    seed   = 38;
    rst    = 1'b1;
    req    = '0;
    flitId = '0;
    pktLen = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // a lone request is granted one cycle later
    waitCycles(2);
    req = 5'b00100;
    @(negedge clk);
    checkVal("grant", 32'h4, 32'(grant));
    req = '0;
    waitCycles(2);

    // from IDLE the lowest port index wins
    req = 5'b11010;
    @(negedge clk);
    checkVal("grant", 32'h2, 32'(grant));
    req = '0;
    waitCycles(2);

    // held requests keep the port for budget+1 cycles
    loadBudget(0, 3);
    loadBudget(1, 2);
    loadBudget(2, 5);
    req = 5'b00001;
    measureTenure(5'b00001, tenure);
    checkVal("tenureL", 32'd4, 32'(tenure));
    checkVal("grant", 32'h0, 32'(grant)); // alone, so one idle cycle
    @(negedge clk);
    checkVal("grant", 32'h1, 32'(grant));
    req = 5'b00011;
    measureTenure(5'b00010, tenure);
    checkVal("tenureN", 32'd3, 32'(tenure));
    checkVal("grant", 32'h1, 32'(grant));

    // dropping the request rotates on from the holder
    req = 5'b10101;
    waitGrant(5'b00100);
    req = 5'b10001;
    @(negedge clk);
    checkVal("grant", 32'h10, 32'(grant));
    req = '0;
    waitCycles(2);

    // body flits leave the budget alone, a head flit replaces it
    flitId[0] = 3'd2;
    pktLen[0] = 12'd9;
    @(negedge clk);
    flitId[0] = '0;
    req = 5'b00001;
    measureTenure(5'b00001, tenure);
    checkVal("tenureL", 32'd4, 32'(tenure));
    req = '0;
    waitCycles(2);
    loadBudget(0, 6);
    req = 5'b00001;
    measureTenure(5'b00001, tenure);
    checkVal("tenureL", 32'd7, 32'(tenure));
    req = '0;
    waitCycles(2);
    loadBudget(3, 0);
    loadBudget(4, 0);
    req = 5'b11000;
    measureTenure(5'b01000, tenure);
    checkVal("tenureW", 32'd1, 32'(tenure));
    measureTenure(5'b10000, tenure);
    checkVal("tenureS", 32'd1, 32'(tenure));
    req = '0;
    waitCycles(2);

    randomPhase(RANDOM_CYCLES);
    req    = '0;
    flitId = '0;
    waitCycles(3);
    @(posedge clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule
